// File: include/rf_config.svh
//////////////////////////////////////////////////
// Register file configuration
// Word, integrity and address widths shared by
// the packages and the storage stage
//////////////////////////////////////////////////

`ifndef RF_CONFIG_SVH
`define RF_CONFIG_SVH

// Data word carried by each register
`define RF_DATA_W   32

// Check bits stored next to each word
`define RF_INTG_W   7

// Register count and index width
`define RF_NUM_REGS 32
`define RF_ADDR_W   5

`endif

// File: logic/rf_types_pkg.sv
//////////////////////////////////////////////////
// Register file types
// Index, data word and the stored integrity word
//////////////////////////////////////////////////

`default_nettype none

`include "rf_config.svh"

package rf_types_pkg;

  typedef logic [`RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [`RF_DATA_W-1:0] rf_data_t;

  // Stored word, check bits sit above the data
  typedef struct packed {
    logic [`RF_INTG_W-1:0] intg;
    rf_data_t              data;
  } rf_word_fields_t;

  // Storage sees a flat vector, the encode and
  // check stages see the field pair
  typedef union packed {
    logic [`RF_INTG_W+`RF_DATA_W-1:0] raw;
    rf_word_fields_t                  fields;
  } rf_word_u;

endpackage

`default_nettype wire

// File: logic/rf_ecc_pkg.sv
//////////////////////////////////////////////////
// Register file integrity
// Check-bit type and the generator used on both
// the write and the read side
//////////////////////////////////////////////////

`default_nettype none

`include "rf_config.svh"

package rf_ecc_pkg;

  import rf_types_pkg::*;

  typedef logic [`RF_INTG_W-1:0] rf_intg_t;

  // Interleaved parity
  // Bit k covers every data bit i with i mod 7 == k
  function automatic rf_intg_t rf_intg_gen(rf_data_t data);
    rf_intg_t intg;
    intg = '0;
    for (int i = 0; i < `RF_DATA_W; i++) begin
      intg[i % `RF_INTG_W] = intg[i % `RF_INTG_W] ^ data[i];
    end
    return intg;
  endfunction

  // All-zero data still encodes through the generator
  function automatic rf_intg_t rf_intg_zero();
    rf_intg_t intg;
    intg = rf_intg_gen('0);
    return intg;
  endfunction

endpackage

`default_nettype wire

// File: logic/rf_wr_encode.sv
//////////////////////////////////////////////////
// Write encode stage
// Registers the write request and attaches the
// check bits, with an optional fault mask
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rf_wr_encode import rf_types_pkg::*; import rf_ecc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Write request
  input  logic     wr_en_i,
  input  rf_addr_t wr_addr_i,
  input  rf_data_t wr_data_i,
  input  rf_intg_t wr_flip_i,

  // Towards storage
  output logic     st_we_o,
  output rf_addr_t st_addr_o,
  output rf_word_u st_word_o
);

  rf_word_u word_d;
  rf_word_u word_q;
  rf_addr_t addr_q;
  logic     we_q;

  // Flip mask disturbs the stored check bits only
  always_comb begin
    word_d.fields.data = wr_data_i;
    word_d.fields.intg = rf_intg_gen(wr_data_i) ^ wr_flip_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else begin
      we_q <= wr_en_i;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      addr_q <= wr_addr_i;
      word_q <= word_d;
    end
  end

  assign st_we_o   = we_q;
  assign st_addr_o = addr_q;
  assign st_word_o = word_q;

endmodule

`default_nettype wire

// File: logic/rf_storage.sv
//////////////////////////////////////////////////
// Register file storage stage
// 31 writable words, x0 hardwired, two
// registered read ports
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rf_config.svh"

module rf_storage import rf_types_pkg::*; import rf_ecc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Write side
  input  logic     st_we_i,
  input  rf_addr_t st_addr_i,
  input  rf_word_u st_word_i,

  // Read request
  input  logic     rd_en_i,
  input  rf_addr_t rd_addr_a_i,
  input  rf_addr_t rd_addr_b_i,

  // Towards the check stage
  output logic     chk_valid_o,
  output rf_word_u chk_word_a_o,
  output rf_word_u chk_word_b_o
);

  localparam int unsigned word_w = `RF_INTG_W + `RF_DATA_W;

  // Encoded zero, also the value of x0
  localparam logic [word_w-1:0] zero_raw = {rf_intg_zero(), rf_data_t'(0)};

  logic [word_w-1:0] mem_q [1:`RF_NUM_REGS-1];

  rf_word_u word_a_d, word_b_d;
  rf_word_u word_a_q, word_b_q;
  logic     valid_q;

  ///////////////////////////////////////////////////
  // Array
  ///////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `RF_NUM_REGS; i++) begin
        mem_q[i] <= zero_raw;
      end
    end else if (st_we_i && (st_addr_i != '0)) begin
      mem_q[st_addr_i] <= st_word_i.raw;
    end
  end

  ///////////////////////////////////////////////////
  // Read ports
  ///////////////////////////////////////////////////

  assign word_a_d.raw = (rd_addr_a_i == '0) ? zero_raw : mem_q[rd_addr_a_i];
  assign word_b_d.raw = (rd_addr_b_i == '0) ? zero_raw : mem_q[rd_addr_b_i];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rd_en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      word_a_q <= word_a_d;
      word_b_q <= word_b_d;
    end
  end

  assign chk_valid_o  = valid_q;
  assign chk_word_a_o = word_a_q;
  assign chk_word_b_o = word_b_q;

endmodule

`default_nettype wire

// File: logic/rf_rd_check.sv
//////////////////////////////////////////////////
// Read check stage
// Recomputes integrity of both read words, flags
// mismatches and holds a sticky major alert
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rf_rd_check import rf_types_pkg::*; import rf_ecc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // From storage
  input  logic     chk_valid_i,
  input  rf_word_u chk_word_a_i,
  input  rf_word_u chk_word_b_i,

  // Read results
  output logic     rd_valid_o,
  output rf_data_t rd_data_a_o,
  output rf_data_t rd_data_b_o,
  output logic     rd_err_a_o,
  output logic     rd_err_b_o,
  output logic     alert_major_o
);

  rf_intg_t intg_a, intg_b;
  logic     err_a_d, err_b_d;

  logic     valid_q;
  logic     err_a_q, err_b_q;
  logic     alert_q;
  rf_data_t data_a_q, data_b_q;

  ///////////////////////////////////////////////////
  // Integrity compare
  ///////////////////////////////////////////////////

  assign intg_a = rf_intg_gen(chk_word_a_i.fields.data);
  assign intg_b = rf_intg_gen(chk_word_b_i.fields.data);

  // Only a valid read may raise a flag
  assign err_a_d = chk_valid_i & (intg_a != chk_word_a_i.fields.intg);
  assign err_b_d = chk_valid_i & (intg_b != chk_word_b_i.fields.intg);

  ///////////////////////////////////////////////////
  // Output registers
  ///////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      err_a_q <= 1'b0;
      err_b_q <= 1'b0;
      alert_q <= 1'b0;
    end else begin
      valid_q <= chk_valid_i;
      err_a_q <= err_a_d;
      err_b_q <= err_b_d;
      // Sticky until reset
      alert_q <= alert_q | err_a_d | err_b_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (chk_valid_i) begin
      data_a_q <= chk_word_a_i.fields.data;
      data_b_q <= chk_word_b_i.fields.data;
    end
  end

  assign rd_valid_o    = valid_q;
  assign rd_data_a_o   = data_a_q;
  assign rd_data_b_o   = data_b_q;
  assign rd_err_a_o    = err_a_q;
  assign rd_err_b_o    = err_b_q;
  assign alert_major_o = alert_q;

endmodule

`default_nettype wire

// File: logic/rf_top.sv
//////////////////////////////////////////////////
// Register file top level
// Two-read, one-write file with integrity,
// chaining encode, storage and check stages
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rf_top import rf_types_pkg::*; import rf_ecc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Write port
  input  logic     wr_en_i,
  input  rf_addr_t wr_addr_i,
  input  rf_data_t wr_data_i,
  input  rf_intg_t wr_flip_i,

  // Read ports
  input  logic     rd_en_i,
  input  rf_addr_t rd_addr_a_i,
  input  rf_addr_t rd_addr_b_i,

  // Read results and alert
  output logic     rd_valid_o,
  output rf_data_t rd_data_a_o,
  output rf_data_t rd_data_b_o,
  output logic     rd_err_a_o,
  output logic     rd_err_b_o,
  output logic     alert_major_o
);

  // Encode to storage
  logic     st_we;
  rf_addr_t st_addr;
  rf_word_u st_word;

  // Storage to check
  logic     chk_valid;
  rf_word_u chk_word_a;
  rf_word_u chk_word_b;

  rf_wr_encode u_wr_encode (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_en_i  (wr_en_i),
    .wr_addr_i(wr_addr_i),
    .wr_data_i(wr_data_i),
    .wr_flip_i(wr_flip_i),
    .st_we_o  (st_we),
    .st_addr_o(st_addr),
    .st_word_o(st_word)
  );

  rf_storage u_storage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .st_we_i     (st_we),
    .st_addr_i   (st_addr),
    .st_word_i   (st_word),
    .rd_en_i     (rd_en_i),
    .rd_addr_a_i (rd_addr_a_i),
    .rd_addr_b_i (rd_addr_b_i),
    .chk_valid_o (chk_valid),
    .chk_word_a_o(chk_word_a),
    .chk_word_b_o(chk_word_b)
  );

  rf_rd_check u_rd_check (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .chk_valid_i  (chk_valid),
    .chk_word_a_i (chk_word_a),
    .chk_word_b_i (chk_word_b),
    .rd_valid_o   (rd_valid_o),
    .rd_data_a_o  (rd_data_a_o),
    .rd_data_b_o  (rd_data_b_o),
    .rd_err_a_o   (rd_err_a_o),
    .rd_err_b_o   (rd_err_b_o),
    .alert_major_o(alert_major_o)
  );

endmodule

`default_nettype wire

// File: sim/rf_top_tb.sv
//////////////////////////////////////////////////
// Register file testbench
// Table-driven writes, reads and resets checked
// against a data and fault-mask model
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rf_config.svh"

module rf_top_tb import rf_types_pkg::*; import rf_ecc_pkg::*; ();

  localparam int op_wr = 0;
  localparam int op_rd = 1;
  localparam int op_rst = 2;
  localparam int timeout_cycles = 20;

  logic     clk, rst_n;
  logic     wr_en, rd_en;
  rf_addr_t wr_addr, rd_addr_a, rd_addr_b;
  rf_data_t wr_data;
  rf_intg_t wr_flip;
  logic     rd_valid, rd_err_a, rd_err_b, alert_major;
  rf_data_t rd_data_a, rd_data_b;
  int       cycle_cnt = 0;

  // Stimulus table, one column per queue
  int       tbl_op[$];
  rf_addr_t tbl_addr_a[$], tbl_addr_b[$];
  rf_data_t tbl_data[$];
  rf_intg_t tbl_flip[$];
  bit       tbl_rnd[$], tbl_chain[$], tbl_alert[$];
  string    tbl_name[$];

  // Model and reads in flight
  rf_data_t ref_data [`RF_NUM_REGS];
  rf_intg_t ref_flip [`RF_NUM_REGS];
  rf_addr_t pend_a[$], pend_b[$];
  int       pend_cycle[$];
  bit       pend_alert[$];
  string    pend_name[$];

  rf_top uut (
    .clk_i(clk), .rst_ni(rst_n),
    .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data), .wr_flip_i(wr_flip),
    .rd_en_i(rd_en), .rd_addr_a_i(rd_addr_a), .rd_addr_b_i(rd_addr_b),
    .rd_valid_o(rd_valid), .rd_data_a_o(rd_data_a), .rd_data_b_o(rd_data_b),
    .rd_err_a_o(rd_err_a), .rd_err_b_o(rd_err_b), .alert_major_o(alert_major)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  task automatic check_data(string name, rf_data_t exp, rf_data_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_cycle(string name, int exp, int act);
    if (act != exp) begin
      $display("CHECK FAILED %s expected cycle %0d actual cycle %0d", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "latency mismatch");
    end
  endtask

  task automatic add_entry(int op, rf_addr_t a, rf_addr_t b, rf_data_t data, rf_intg_t flip,
                           bit rnd, bit chain, bit exp_alert, string name);
    tbl_op.push_back(op);
    tbl_addr_a.push_back(a);
    tbl_addr_b.push_back(b);
    tbl_data.push_back(data);
    tbl_flip.push_back(flip);
    tbl_rnd.push_back(rnd);
    tbl_chain.push_back(chain);
    tbl_alert.push_back(exp_alert);
    tbl_name.push_back(name);
  endtask

  task automatic clear_model();
    for (int i = 0; i < `RF_NUM_REGS; i++) begin
      ref_data[i] = '0;
      ref_flip[i] = '0;
    end
  endtask

  task automatic apply_reset();
    rst_n <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    clear_model();
  endtask

  task automatic wait_valid(output int at_cycle);
    int waited;
    waited = 0;
    @(negedge clk);
    while (rd_valid !== 1'b1) begin
      if (waited >= timeout_cycles) begin
        $display("Timeout: read valid never arrived");
        $display("SIMULATION FAILED");
        $fatal(1, "read timeout");
      end
      waited++;
      @(negedge clk);
    end
    at_cycle = cycle_cnt;
  endtask

  // Results come back in issue order, at most two in flight
  task automatic drain_reads();
    int       at_cycle;
    rf_addr_t a, b;
    string    name;
    while (pend_a.size() > 0) begin
      wait_valid(at_cycle);
      a = pend_a.pop_front();
      b = pend_b.pop_front();
      name = pend_name.pop_front();
      check_cycle({name, " latency"}, pend_cycle.pop_front() + 2, at_cycle);
      check_data({name, " data a"}, ref_data[a], rd_data_a);
      check_data({name, " data b"}, ref_data[b], rd_data_b);
      check_bit({name, " err a"}, ref_flip[a] != '0, rd_err_a);
      check_bit({name, " err b"}, ref_flip[b] != '0, rd_err_b);
      check_bit({name, " alert"}, pend_alert.pop_front(), alert_major);
    end
    @(negedge clk);
    check_bit("valid single cycle", 1'b0, rd_valid);
  endtask

  task automatic apply_entry(int idx);
    rf_data_t data;
    rf_addr_t a;
    data = tbl_rnd[idx] ? rf_data_t'($urandom()) : tbl_data[idx];
    a = tbl_addr_a[idx];
    @(posedge clk);
    case (tbl_op[idx])
      op_wr: begin
        wr_en <= 1'b1;
        wr_addr <= a;
        wr_data <= data;
        wr_flip <= tbl_flip[idx];
        rd_en <= 1'b0;
        // x0 ignores writes
        if (a != '0) begin
          ref_data[a] = data;
          ref_flip[a] = tbl_flip[idx];
        end
      end
      op_rd: begin
        rd_en <= 1'b1;
        rd_addr_a <= a;
        rd_addr_b <= tbl_addr_b[idx];
        wr_en <= 1'b0;
        @(negedge clk);
        pend_a.push_back(a);
        pend_b.push_back(tbl_addr_b[idx]);
        pend_cycle.push_back(cycle_cnt);
        pend_alert.push_back(tbl_alert[idx]);
        pend_name.push_back(tbl_name[idx]);
      end
      default: begin
        wr_en <= 1'b0;
        rd_en <= 1'b0;
        apply_reset();
      end
    endcase
    if (!tbl_chain[idx]) begin
      @(posedge clk);
      wr_en <= 1'b0;
      rd_en <= 1'b0;
      drain_reads();
    end
  endtask

  task automatic build_table();
    // op, addr a, addr b, data, flip, random, chained, alert, name
    add_entry(op_rd, 5'd1, 5'd2, '0, '0, 0, 1, 0, "reset read 1 2");
    add_entry(op_rd, 5'd0, 5'd31, '0, '0, 0, 0, 0, "reset read 0 31");
    add_entry(op_wr, 5'd5, 5'd0, '0, '0, 1, 0, 0, "write r5");
    add_entry(op_wr, 5'd9, 5'd0, 32'hdeadbeef, '0, 0, 0, 0, "write r9");
    add_entry(op_wr, 5'd31, 5'd0, '0, '0, 1, 0, 0, "write r31");
    add_entry(op_rd, 5'd5, 5'd9, '0, '0, 0, 1, 0, "read 5 9");
    add_entry(op_rd, 5'd31, 5'd5, '0, '0, 0, 0, 0, "read 31 5");
    add_entry(op_rd, 5'd9, 5'd31, '0, '0, 0, 0, 0, "read 9 31");
    add_entry(op_wr, 5'd0, 5'd0, 32'h12345678, '0, 0, 0, 0, "write r0");
    add_entry(op_rd, 5'd0, 5'd5, '0, '0, 0, 0, 0, "read 0 after write");
    add_entry(op_wr, 5'd12, 5'd0, 32'hcafef00d, 7'h05, 0, 0, 0, "fault write r12");
    add_entry(op_rd, 5'd12, 5'd9, '0, '0, 0, 0, 1, "fault read 12 9");
    add_entry(op_rd, 5'd9, 5'd12, '0, '0, 0, 0, 1, "fault read 9 12");
    add_entry(op_rd, 5'd5, 5'd31, '0, '0, 0, 0, 1, "clean read sticky");
    add_entry(op_wr, 5'd12, 5'd0, 32'h0badf00d, '0, 0, 0, 1, "rewrite r12");
    add_entry(op_rd, 5'd12, 5'd12, '0, '0, 0, 0, 1, "read rewritten 12");
    add_entry(op_rst, 5'd0, 5'd0, '0, '0, 0, 0, 0, "mid reset");
    add_entry(op_rd, 5'd12, 5'd9, '0, '0, 0, 0, 0, "read after reset");
  endtask

  initial begin
    void'($urandom(32'h9e3c41af));
    rst_n = 1'b0;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    wr_flip = '0;
    rd_en = 1'b0;
    rd_addr_a = '0;
    rd_addr_b = '0;
    build_table();
    clear_model();
    apply_reset();
    for (int i = 0; i < tbl_op.size(); i++) begin
      apply_entry(i);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
logic/rf_types_pkg.sv
logic/rf_ecc_pkg.sv
logic/rf_wr_encode.sv
logic/rf_storage.sv
logic/rf_rd_check.sv
logic/rf_top.sv
sim/rf_top_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the register file testbench with Verilator

verilator --binary --timing -f vlog.f --top-module rf_top_tb -o rf_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/rf_sim > sim.log 2>&1

grep -q "^SIMULATION PASSED$" sim.log && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
